//--- filelist.f
+incdir+source
source/stream_alu_pkg.sv
source/sync_fifo.sv
source/axis_fifo.sv
source/op_decode.sv
source/alu_execute.sv
source/stream_alu_top.sv
verif/stream_alu_chk.sv
verif/stream_alu_tb.sv

//--- source/alu_execute.sv
// execute stage: computes the 16-bit result of a micro-op
// and keeps the packet accumulator, cleared on last.

`timescale 1ns/1ps
`include "stream_alu_params.svh"

module alu_execute import stream_alu_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic uop_valid_i,
    input  uop_t uop_i,
    output logic uop_ready_o,
    output logic res_valid_o,
    output res_t res_o,
    input  logic res_ready_i
);

    logic  valid_q;
    res_t  res_q;
    data_t acc_q;
    data_t acc_sum;
    data_t value;
    logic  take;

    assign uop_ready_o = ~valid_q | res_ready_i;
    assign take        = uop_valid_i & uop_ready_o;
    assign acc_sum     = acc_q + uop_i.a; // wraps.

    always_comb begin
        case (uop_i.alu_sel)
            ALU_ADD: value = uop_i.a + uop_i.b;
            ALU_SUB: value = uop_i.a - uop_i.b;
            ALU_AND: value = uop_i.a & uop_i.b;
            ALU_OR:  value = uop_i.a | uop_i.b;
            ALU_XOR: value = uop_i.a ^ uop_i.b;
            ALU_SHL: value = uop_i.a << uop_i.b[`SA_SHAMT_W-1:0];
            default: value = '0;
        endcase
        if (uop_i.acc_en) value = acc_sum;
        if (uop_i.illegal) value = '0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            acc_q   <= '0;
        end else begin
            if (uop_ready_o) valid_q <= uop_valid_i;
            if (take) begin
                if (uop_i.last) begin
                    acc_q <= '0; // packet end, after this beat's output.
                end else if (uop_i.acc_en && !uop_i.illegal) begin
                    acc_q <= acc_sum;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) res_q <= '{value: value, err: uop_i.illegal, last: uop_i.last};
    end

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

endmodule

//--- source/axis_fifo.sv
// stream FIFO wrapper around sync_fifo.
// tvalid/tready handshakes become push and pop.

`timescale 1ns/1ps

module axis_fifo import stream_alu_pkg::*; #(
    parameter int  DEPTH = 8,
    parameter type T     = cmd_t
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   s_tvalid_i,
    input  T                       s_data_i,
    output logic                   s_tready_o,
    output logic                   m_tvalid_o,
    output T                       m_data_o,
    input  logic                   m_tready_i,
    output logic                   a_full_o,
    output logic                   a_empty_o,
    output logic [$clog2(DEPTH):0] data_cnt_o
);

    localparam int WIDTH = $bits(T);

    logic [WIDTH-1:0] rd_data;
    logic             push;
    logic             pop;
    logic             empty;
    logic             full;

    assign s_tready_o = ~full;
    assign m_tvalid_o = ~empty;
    assign m_data_o   = T'(rd_data);

    assign push = s_tvalid_i & s_tready_o;
    assign pop  = m_tvalid_o & m_tready_i;

    sync_fifo #(
        .WIDTH(WIDTH),
        .DEPTH(DEPTH)
    ) u_sync_fifo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .data_i    (s_data_i),
        .push_i    (push),
        .pop_i     (pop),
        .data_o    (rd_data),
        .empty_o   (empty),
        .full_o    (full),
        .a_empty_o (a_empty_o),
        .a_full_o  (a_full_o),
        .data_cnt_o(data_cnt_o)
    );

endmodule

//--- source/op_decode.sv
// decode stage: one-entry register turning a command
// into alu controls, accumulate enable and illegal flag.

`timescale 1ns/1ps

module op_decode import stream_alu_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic cmd_valid_i,
    input  cmd_t cmd_i,
    output logic cmd_ready_o,
    output logic uop_valid_o,
    output uop_t uop_o,
    input  logic uop_ready_i
);

    logic valid_q;
    uop_t uop_q;
    uop_t uop_d;

    // free slot, or the held item leaves this cycle.
    assign cmd_ready_o = ~valid_q | uop_ready_i;

    always_comb begin
        uop_d.alu_sel = ALU_ADD;
        uop_d.acc_en  = 1'b0;
        uop_d.illegal = 1'b0;
        uop_d.a       = cmd_i.a;
        uop_d.b       = cmd_i.b;
        uop_d.last    = cmd_i.last;
        case (cmd_i.opcode)
            OP_ADD: uop_d.alu_sel = ALU_ADD;
            OP_SUB: uop_d.alu_sel = ALU_SUB;
            OP_AND: uop_d.alu_sel = ALU_AND;
            OP_OR:  uop_d.alu_sel = ALU_OR;
            OP_XOR: uop_d.alu_sel = ALU_XOR;
            OP_SHL: uop_d.alu_sel = ALU_SHL;
            OP_ACC: uop_d.acc_en  = 1'b1; // sum goes through the adder.
            default: uop_d.illegal = 1'b1; // OP_RSV.
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (cmd_ready_o) begin
            valid_q <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i & cmd_ready_o) begin
            uop_q <= uop_d;
        end
    end

    assign uop_valid_o = valid_q;
    assign uop_o       = uop_q;

endmodule

//--- source/stream_alu_params.svh
// global sizing macros for the stream arithmetic unit.
// operand width, shift amount width and the two FIFO depths.

`ifndef STREAM_ALU_PARAMS_SVH
`define STREAM_ALU_PARAMS_SVH

// operand and result width.
`define SA_DATA_W 16

// shift amount bits taken from operand b.
`define SA_SHAMT_W 4

// input command FIFO depth.
`define SA_IN_DEPTH 8

// result FIFO depth, also sets the status count width.
`define SA_OUT_DEPTH 8

`endif

//--- source/stream_alu_pkg.sv
// shared types: opcode and alu select enums,
// command beat, decoded micro-op and result structs.

`include "stream_alu_params.svh"

package stream_alu_pkg;

    typedef logic [`SA_DATA_W-1:0] data_t;

    // command opcodes, OP_RSV is illegal.
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SHL = 3'd5,
        OP_ACC = 3'd6,
        OP_RSV = 3'd7
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5
    } alu_sel_e;

    typedef struct packed {
        opcode_e opcode;
        data_t   a;
        data_t   b;
        logic    last;
    } cmd_t; // slave tdata plus tlast.

    typedef struct packed {
        alu_sel_e alu_sel;
        logic     acc_en;
        logic     illegal;
        data_t    a;
        data_t    b;
        logic     last;
    } uop_t;

    typedef struct packed {
        data_t value;
        logic  err;
        logic  last;
    } res_t; // master tdata plus tlast.

endpackage

//--- source/stream_alu_top.sv
// top level of the stream arithmetic unit.
// input FIFO, decode, execute and result FIFO in a chain.

`timescale 1ns/1ps
`include "stream_alu_params.svh"

module stream_alu_top import stream_alu_pkg::*; (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           s_tvalid_i,
    input  cmd_t                           s_cmd_i,
    output logic                           s_tready_o,
    output logic                           m_tvalid_o,
    output res_t                           m_res_o,
    input  logic                           m_tready_i,
    output logic                           m_a_full_o,
    output logic                           m_a_empty_o,
    output logic [$clog2(`SA_OUT_DEPTH):0] m_data_cnt_o
);

    logic in_valid;
    cmd_t in_cmd;
    logic in_ready;
    logic dec_valid;
    uop_t dec_uop;
    logic dec_ready;
    logic ex_valid;
    res_t ex_res;
    logic ex_ready;

    axis_fifo #(
        .DEPTH(`SA_IN_DEPTH),
        .T    (cmd_t)
    ) u_in_fifo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .s_tvalid_i(s_tvalid_i),
        .s_data_i  (s_cmd_i),
        .s_tready_o(s_tready_o),
        .m_tvalid_o(in_valid),
        .m_data_o  (in_cmd),
        .m_tready_i(in_ready),
        .a_full_o  (),
        .a_empty_o (),
        .data_cnt_o()
    );

    op_decode u_decode (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .cmd_valid_i(in_valid),
        .cmd_i      (in_cmd),
        .cmd_ready_o(in_ready),
        .uop_valid_o(dec_valid),
        .uop_o      (dec_uop),
        .uop_ready_i(dec_ready)
    );

    alu_execute u_execute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .uop_valid_i(dec_valid),
        .uop_i      (dec_uop),
        .uop_ready_o(dec_ready),
        .res_valid_o(ex_valid),
        .res_o      (ex_res),
        .res_ready_i(ex_ready)
    );

    // result FIFO status goes out on the top ports.
    axis_fifo #(
        .DEPTH(`SA_OUT_DEPTH),
        .T    (res_t)
    ) u_res_fifo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .s_tvalid_i(ex_valid),
        .s_data_i  (ex_res),
        .s_tready_o(ex_ready),
        .m_tvalid_o(m_tvalid_o),
        .m_data_o  (m_res_o),
        .m_tready_i(m_tready_i),
        .a_full_o  (m_a_full_o),
        .a_empty_o (m_a_empty_o),
        .data_cnt_o(m_data_cnt_o)
    );

endmodule

//--- source/sync_fifo.sv
// synchronous register-array FIFO.
// push/pop with full/empty, almost flags and occupancy count.

`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [WIDTH-1:0]         data_i,
    input  logic                     push_i,
    input  logic                     pop_i,
    output logic [WIDTH-1:0]         data_o,
    output logic                     empty_o,
    output logic                     full_o,
    output logic                     a_empty_o,
    output logic                     a_full_o,
    output logic [$clog2(DEPTH):0]   data_cnt_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (cnt == CNT_W'(DEPTH));
    assign empty_o = (cnt == '0);

    assign do_push = push_i & ~full_o; // overflow is dropped.
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    assign data_o = mem[rd_ptr]; // combinational read.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // almost flags straight off the counter.
    assign a_full_o   = (cnt >= CNT_W'(DEPTH - 1));
    assign a_empty_o  = (cnt <= CNT_W'(1));
    assign data_cnt_o = cnt;

endmodule

//--- verif/stream_alu_chk.sv
// handshake checker bound to stream_alu_top.
// stable valid/data under back-pressure, reset quiet, result count range.

`timescale 1ns/1ps
`include "stream_alu_params.svh"

module stream_alu_chk import stream_alu_pkg::*; (
    input logic                           clk_i,
    input logic                           arst_n_i,
    input logic                           s_tvalid_i,
    input cmd_t                           s_cmd_i,
    input logic                           s_tready_i,
    input logic                           m_tvalid_i,
    input res_t                           m_res_i,
    input logic                           m_tready_i,
    input logic [$clog2(`SA_OUT_DEPTH):0] m_data_cnt_i
);

    // a stalled beat stays offered and unchanged.
    s_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_tvalid_i && !s_tready_i |=> s_tvalid_i && $stable(s_cmd_i))
        else $error("slave beat changed while stalled");

    m_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_res_i))
        else $error("master beat changed while stalled");

    reset_quiet_a: assert property (@(posedge clk_i)
        !arst_n_i |-> !(s_tvalid_i && s_tready_i) && !(m_tvalid_i && m_tready_i))
        else $error("transfer during reset");

    cnt_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        m_data_cnt_i <= `SA_OUT_DEPTH)
        else $error("result count above depth");

endmodule

bind stream_alu_top stream_alu_chk u_chk (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .s_tvalid_i  (s_tvalid_i),
    .s_cmd_i     (s_cmd_i),
    .s_tready_i  (s_tready_o),
    .m_tvalid_i  (m_tvalid_o),
    .m_res_i     (m_res_o),
    .m_tready_i  (m_tready_i),
    .m_data_cnt_i(m_data_cnt_o)
);

//--- verif/stream_alu_tb.sv
// directed testbench for stream_alu_top.
// clock, reset, queue reference model, compare tasks, tests and watchdog.

`timescale 1ns/1ps
`include "stream_alu_params.svh"

module stream_alu_tb import stream_alu_pkg::*; ();

    localparam int CNT_W       = $clog2(`SA_OUT_DEPTH) + 1;
    localparam int N_RANDOM    = 200;
    localparam int TOTAL_BEATS = 6 + 9 + 3 + 18 + N_RANDOM; // beats over all tests.

    logic             clk = 1'b0;
    logic             arst_n_i;
    logic             s_tvalid_i;
    cmd_t             s_cmd_i;
    logic             s_tready_o;
    logic             m_tvalid_o;
    res_t             m_res_o;
    logic             m_tready_i;
    logic             m_a_full_o;
    logic             m_a_empty_o;
    logic [CNT_W-1:0] m_data_cnt_o;

    res_t   exp_q[$];          // expected results in order.
    data_t  model_acc = '0;
    integer seed = 61705;
    logic   rand_ready = 1'b0;
    cmd_t   rnd_cmd[N_RANDOM];

    stream_alu_top DUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_cmd_i     (s_cmd_i),
        .s_tready_o  (s_tready_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_res_o     (m_res_o),
        .m_tready_i  (m_tready_i),
        .m_a_full_o  (m_a_full_o),
        .m_a_empty_o (m_a_empty_o),
        .m_data_cnt_o(m_data_cnt_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    // reference: result from the opcode rules, own accumulator.
    function automatic res_t model_step(input cmd_t c);
        res_t r;
        r.value = '0;
        r.err   = 1'b0;
        r.last  = c.last;
        case (c.opcode)
            OP_ADD: r.value = c.a + c.b;
            OP_SUB: r.value = c.a - c.b;
            OP_AND: r.value = c.a & c.b;
            OP_OR:  r.value = c.a | c.b;
            OP_XOR: r.value = c.a ^ c.b;
            OP_SHL: r.value = c.a << c.b[3:0];
            OP_ACC: begin
                r.value   = model_acc + c.a;
                model_acc = r.value;
            end
            default: r.err = 1'b1;
        endcase
        if (c.last) model_acc = '0;
        return r;
    endfunction

    task automatic check_res(input res_t got, input res_t exp);
        if (got !== exp) begin
            $display("ERR %0t: result got value=%h err=%b last=%b, exp value=%h err=%b last=%b",
                     $time, got.value, got.err, got.last, exp.value, exp.err, exp.last);
            abort_run();
        end
    endtask

    task automatic check_status(input logic [CNT_W-1:0] exp_cnt, input logic exp_af,
                                input logic exp_ae);
        if (m_data_cnt_o !== exp_cnt || m_a_full_o !== exp_af || m_a_empty_o !== exp_ae) begin
            $display("ERR %0t: status got cnt=%0d af=%b ae=%b, exp cnt=%0d af=%b ae=%b",
                     $time, m_data_cnt_o, m_a_full_o, m_a_empty_o, exp_cnt, exp_af, exp_ae);
            abort_run();
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // output side, sampled mid-cycle where all signals are settled.
    always @(negedge clk) begin
        if (arst_n_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
                $display("ERR %0t: result appeared with nothing expected", $time);
                abort_run();
            end else begin
                check_res(m_res_o, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rand_ready) begin
            #2;
            m_tready_i = ($random(seed) & 3) != 0;
        end
    end

    // called and returning at 2 ns past a rising edge.
    task automatic send_beat(input opcode_e op, input data_t a, input data_t b,
                             input logic last);
        cmd_t c;
        c.opcode   = op;
        c.a        = a;
        c.b        = b;
        c.last     = last;
        s_cmd_i    = c;
        s_tvalid_i = 1'b1;
        @(negedge clk);
        while (!s_tready_o) @(negedge clk);
        exp_q.push_back(model_step(c));
        @(posedge clk);
        #2;
        s_tvalid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("results missing: %0d still expected after drain", exp_q.size());
            abort_run();
        end
    endtask

    task automatic reset_state();
        expect_level("m_tvalid_o", m_tvalid_o, 1'b0);
        expect_level("s_tready_o", s_tready_o, 1'b1);
        check_status('0, 1'b0, 1'b1);
    endtask

    task automatic opcode_sweep();
        opcode_e ops[6];
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
        foreach (ops[i]) begin
            send_beat(ops[i], 16'hf0f3 + 16'(i), 16'h8f35, 1'b0);
            // four register edges counting the FIFO write edge.
            for (int k = 0; k < 4; k++) begin
                if (k > 0) begin
                    @(posedge clk);
                    #2;
                end
                expect_level("m_tvalid_o latency", m_tvalid_o, k == 3);
            end
            wait_drain();
        end
    endtask

    task automatic accumulate_packets();
        for (int i = 1; i <= 5; i++) send_beat(OP_ACC, 16'(i), 16'h0, i == 5);
        send_beat(OP_ACC, 16'd10, 16'h0, 1'b0);
        send_beat(OP_ADD, 16'd7, 16'd8, 1'b0);
        send_beat(OP_ACC, 16'hfff8, 16'h0, 1'b0); // wraps.
        send_beat(OP_ACC, 16'd5, 16'h0, 1'b1);
        wait_drain();
    endtask

    task automatic reserved_opcode();
        send_beat(OP_ACC, 16'd100, 16'h0, 1'b0);
        send_beat(OP_RSV, 16'h1234, 16'h5678, 1'b0);
        send_beat(OP_ACC, 16'd1, 16'h0, 1'b1);
        wait_drain();
    endtask

    task automatic backpressure_fill();
        int accepted;
        accepted   = 0;
        m_tready_i = 1'b0;
        while (s_tready_o && accepted < 30) begin
            send_beat(opcode_e'(accepted % 7), 16'(accepted * 3), 16'(accepted), 1'b0);
            accepted++;
        end
        if (accepted != 18) begin
            $display("ERR %0t: %0d beats accepted under back-pressure, expected 18",
                     $time, accepted);
            abort_run();
        end
        check_status(CNT_W'(`SA_OUT_DEPTH), 1'b1, 1'b0);
        m_tready_i = 1'b1;
        wait_drain();
        check_status('0, 1'b0, 1'b1);
    endtask

    task automatic random_stream();
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd_cmd[i].opcode = opcode_e'($random(seed) & 7);
            rnd_cmd[i].a      = $random(seed);
            rnd_cmd[i].b      = $random(seed);
            rnd_cmd[i].last   = ($random(seed) & 7) == 0;
        end
        rand_ready = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_beat(rnd_cmd[i].opcode, rnd_cmd[i].a, rnd_cmd[i].b, rnd_cmd[i].last);
            if (i % 7 == 3) begin
                @(posedge clk);
                #2;
            end
        end
        rand_ready = 1'b0;
        @(posedge clk);
        #2;
        m_tready_i = 1'b1;
        wait_drain();
    endtask

    initial begin
        repeat (TOTAL_BEATS * 40 + 2000) @(posedge clk);
        $display("timeout: the tests did not finish in time");
        abort_run();
    end

    initial begin
        arst_n_i   = 1'b0;
        s_tvalid_i = 1'b0;
        s_cmd_i    = '0;
        m_tready_i = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        reset_state();
        opcode_sweep();
        accumulate_packets();
        reserved_opcode();
        backpressure_fill();
        random_stream();
        $display("Done: no errors");
        $finish;
    end

endmodule
